//--- common/fp_sqrt_config.svh
`ifndef FP_SQRT_CONFIG_SVH
`define FP_SQRT_CONFIG_SVH

// single precision layout
`define FP_FLEN        32
`define FP_EXPO_WIDTH  8
`define FP_FRAC_WIDTH  23
`define FP_BIAS        127

// hidden bit + fraction + guard, round, sticky
`define FP_SQRT_ITER   (`FP_FRAC_WIDTH + 1 + 3)

// issue tag
`define FP_ID_WIDTH    4

`define FP_CANONICAL_NAN 32'h7fc0_0000

`endif

//--- common/fp_sqrt_pkg.sv
package fp_sqrt_pkg;

  //////////////////////////////////////////////////
  // rounding modes, riscv frm encoding
  typedef enum logic [2:0] {
    RNE = 3'b000,  // nearest, ties to even
    RTZ = 3'b001,  // toward zero
    RDN = 3'b010,  // toward -inf
    RUP = 3'b011,  // toward +inf
    RMM = 3'b100   // nearest, ties away
  } rounding_mode_t;

  //////////////////////////////////////////////////
  // mantissa core FSM
  typedef enum logic [1:0] {
    SQ_IDLE,
    SQ_BUSY,
    SQ_DONE
  } sqrt_state_t;

  // operand class seen by the issue side
  typedef enum logic [2:0] {
    SC_NORMAL,
    SC_NAN,     // nan, -inf or negative normal
    SC_INF,
    SC_ZERO,    // zero or subnormal
    SC_ONE
  } special_class_t;

endpackage

//--- fp_sqrt.f
+incdir+common
common/fp_sqrt_pkg.sv
fp_sqrt/sqrt_mantissa.sv
fp_sqrt/fp_sqrt.sv
rtl/fp_wb_round.sv
rtl/fp_sqrt_top.sv
verif/tb_clk_gen.sv
verif/fp_sqrt_assert.sv
verif/tb_fp_sqrt.sv

//--- fp_sqrt/fp_sqrt.sv
`timescale 1ns/1ps
`include "fp_sqrt_config.svh"

module fp_sqrt (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        new_request,
  input  logic [`FP_ID_WIDTH-1:0]     id,
  input  logic [`FP_FLEN-1:0]         rs1,
  input  fp_sqrt_pkg::rounding_mode_t rm,
  output logic                        ready,
  output logic                        wb_done,
  output logic [`FP_ID_WIDTH-1:0]     wb_id,
  output logic [`FP_FLEN-1:0]         wb_rd,
  output logic [2:0]                  wb_grs,
  output fp_sqrt_pkg::rounding_mode_t wb_rm,
  output logic [4:0]                  wb_fflags,
  input  logic                        wb_ack
);
  import fp_sqrt_pkg::*;

  localparam int FLEN = `FP_FLEN;
  localparam int EW   = `FP_EXPO_WIDTH;
  localparam int FW   = `FP_FRAC_WIDTH;
  localparam int ITER = `FP_SQRT_ITER;
  localparam logic [EW:0] BIAS_X = `FP_BIAS;

  //////////////////////////////////////////////////
  // one entry input queue
  logic                    q_valid;
  logic [FLEN-1:0]         q_rs1;
  logic [`FP_ID_WIDTH-1:0] q_id;
  rounding_mode_t          q_rm;
  logic                    pop;
  logic                    in_progress;  // core owned until wb ack
  logic                    done_r;
  logic                    mant_done;

  assign pop   = q_valid & ~in_progress;
  assign ready = ~q_valid | pop;

  always_ff @(posedge clk) begin
    if (new_request) begin
      q_rs1 <= rs1;
      q_id  <= id;
      q_rm  <= rm;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      q_valid     <= 1'b0;
      in_progress <= 1'b0;
      done_r      <= 1'b0;
    end else begin
      if (new_request) begin
        q_valid <= 1'b1;
      end else if (pop) begin
        q_valid <= 1'b0;
      end
      if (pop) begin
        in_progress <= 1'b1;
      end else if (wb_ack) begin
        in_progress <= 1'b0;
      end
      if (wb_ack) begin
        done_r <= 1'b0;
      end else if (mant_done) begin
        done_r <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // special operands
  logic            sign;
  logic [EW-1:0]   expo;
  logic [FW-1:0]   frac;
  logic            frac_zero;
  special_class_t  cls;
  logic            nv;
  logic            early;
  logic [FLEN-1:0] early_result;

  assign sign      = q_rs1[FLEN-1];
  assign expo      = q_rs1[FLEN-2 -: EW];
  assign frac      = q_rs1[FW-1:0];
  assign frac_zero = ~|frac;

  always_comb begin
    cls = SC_NORMAL;
    nv  = 1'b0;
    if ((&expo) & ~frac_zero) begin
      cls = SC_NAN;
      nv  = ~frac[FW-1];  // signalling nan only
    end else if (~|expo) begin
      cls = SC_ZERO;      // subnormal flushed, sign kept
    end else if (sign) begin
      cls = SC_NAN;       // negative, -inf included
      nv  = 1'b1;
    end else if (&expo) begin
      cls = SC_INF;
    end else if (({1'b0, expo} == BIAS_X) & frac_zero) begin
      cls = SC_ONE;
    end
  end

  assign early = (cls != SC_NORMAL);

  always_comb begin
    case (cls)
      SC_NAN:  early_result = `FP_CANONICAL_NAN;
      SC_INF:  early_result = {1'b0, {EW{1'b1}}, {FW{1'b0}}};
      SC_ZERO: early_result = {sign, {(FLEN-1){1'b0}}};
      default: early_result = {2'b00, {(EW-1){1'b1}}, {FW{1'b0}}};  // 1.0
    endcase
  end

  //////////////////////////////////////////////////
  // exponent halving and alignment
  logic signed [EW:0] unbiased_expo;
  logic signed [EW:0] half_expo;
  logic [EW:0]        result_expo;
  logic [FW:0]        significand;
  logic [ITER-1:0]    radicand;

  assign unbiased_expo = {1'b0, expo} - BIAS_X;
  assign half_expo     = unbiased_expo >>> 1;  // floor
  assign result_expo   = half_expo + BIAS_X;
  assign significand   = {1'b1, frac};

  // odd exponent takes sqrt(2m), root lands in [sqrt2, 2)
  assign radicand = unbiased_expo[0] ? {significand, 3'b000} : {1'b0, significand, 2'b00};

  //////////////////////////////////////////////////
  // in flight op
  logic [`FP_ID_WIDTH-1:0] op_id;
  rounding_mode_t          op_rm;
  logic                    op_early;
  logic [FLEN-1:0]         op_early_result;
  logic                    op_nv;
  logic [EW-1:0]           op_expo;
  logic [ITER-1:0]         root;

  always_ff @(posedge clk) begin
    if (pop) begin
      op_id           <= q_id;
      op_rm           <= q_rm;
      op_early        <= early;
      op_early_result <= early_result;
      op_nv           <= nv;
      op_expo         <= result_expo[EW-1:0];
    end
  end

  sqrt_mantissa i_sqrt_mantissa (
    .clk             (clk),
    .arst_n          (arst_n),
    .start           (pop),
    .radicand        (radicand),
    .early_terminate (early),
    .done            (mant_done),
    .root            (root)
  );

  //////////////////////////////////////////////////
  // writeback
  assign wb_done   = done_r;
  assign wb_id     = op_id;
  assign wb_rm     = op_rm;
  assign wb_grs    = op_early ? 3'b000 : root[2:0];
  assign wb_rd     = op_early ? op_early_result : {1'b0, op_expo, root[ITER-2 -: FW]};
  assign wb_fflags = {op_nv, 3'b000, |wb_grs};  // nv dz of uf nx

endmodule

//--- fp_sqrt/sqrt_mantissa.sv
`timescale 1ns/1ps
`include "fp_sqrt_config.svh"

module sqrt_mantissa (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     start,
  input  logic [`FP_SQRT_ITER-1:0] radicand,
  input  logic                     early_terminate,
  output logic                     done,
  output logic [`FP_SQRT_ITER-1:0] root
);
  import fp_sqrt_pkg::*;

  localparam int ITER  = `FP_SQRT_ITER;
  localparam int CNT_W = $clog2(ITER);

  sqrt_state_t      state;
  logic [CNT_W-1:0] iter_cnt;   // root bits produced so far
  logic             launch;
  logic             last_iter;

  logic [ITER-1:0]  rad_r;      // radicand pairs not yet consumed
  logic [ITER+1:0]  rem_r;
  logic [ITER-1:0]  root_r;

  logic [ITER-1:0]  rad_cur;
  logic [ITER+1:0]  rem_cur;
  logic [ITER-1:0]  root_cur;
  logic [ITER+1:0]  rem_shift;
  logic [ITER+2:0]  trial;
  logic             q_bit;
  logic [ITER+1:0]  rem_next;
  logic             root_bit;

  assign launch    = start & (state != SQ_BUSY);
  assign last_iter = (state == SQ_BUSY) & (iter_cnt == CNT_W'(ITER - 1));

  //////////////////////////////////////////////////
  // one restoring step per cycle
  // first step runs straight off the incoming radicand
  assign rad_cur  = launch ? radicand : rad_r;
  assign rem_cur  = launch ? '0 : rem_r;
  assign root_cur = launch ? '0 : root_r;

  assign rem_shift = {rem_cur[ITER-1:0], rad_cur[ITER-1 -: 2]};
  assign trial     = {1'b0, rem_shift} - {2'b00, root_cur[ITER-2:0], 2'b01};
  assign q_bit     = ~trial[ITER+2];  // no borrow
  assign rem_next  = q_bit ? trial[ITER+1:0] : rem_shift;

  // leftover remainder folds into the last bit as sticky
  assign root_bit = q_bit | (last_iter & (|rem_next));

  always_ff @(posedge clk) begin
    if (launch | (state == SQ_BUSY)) begin
      rad_r  <= {rad_cur[ITER-3:0], 2'b00};
      rem_r  <= rem_next;
      root_r <= {root_cur[ITER-2:0], root_bit};
    end
  end

  //////////////////////////////////////////////////
  // control
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= SQ_IDLE;
      iter_cnt <= '0;
    end else if (launch) begin
      iter_cnt <= CNT_W'(1);
      if (early_terminate) begin
        state <= SQ_DONE;  // special operand, result comes from issue side
      end else begin
        state <= SQ_BUSY;
      end
    end else if (last_iter) begin
      state <= SQ_DONE;
    end else if (state == SQ_BUSY) begin
      iter_cnt <= iter_cnt + 1'b1;
    end else begin
      state <= SQ_IDLE;  // done is a single cycle
    end
  end

  assign done = (state == SQ_DONE);
  assign root = root_r;  // holds until next launch

endmodule

//--- rtl/fp_sqrt_top.sv
`timescale 1ns/1ps
`include "fp_sqrt_config.svh"

module fp_sqrt_top (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        new_request,
  input  logic [`FP_ID_WIDTH-1:0]     id,
  input  logic [`FP_FLEN-1:0]         rs1,
  input  fp_sqrt_pkg::rounding_mode_t rm,
  output logic                        ready,
  output logic                        result_valid,
  output logic [`FP_FLEN-1:0]         result,
  output logic [`FP_ID_WIDTH-1:0]     result_id,
  output logic [4:0]                  result_fflags,
  input  logic                        result_ack
);
  import fp_sqrt_pkg::*;

  //////////////////////////////////////////////////
  // issue side to writeback
  logic                    wb_done;
  logic                    wb_ack;
  logic [`FP_ID_WIDTH-1:0] wb_id;
  logic [`FP_FLEN-1:0]     wb_rd;     // truncated, not yet rounded
  logic [2:0]              wb_grs;
  rounding_mode_t          wb_rm;
  logic [4:0]              wb_fflags;

  fp_sqrt i_fp_sqrt (
    .clk         (clk),
    .arst_n      (arst_n),
    .new_request (new_request),
    .id          (id),
    .rs1         (rs1),
    .rm          (rm),
    .ready       (ready),
    .wb_done     (wb_done),
    .wb_id       (wb_id),
    .wb_rd       (wb_rd),
    .wb_grs      (wb_grs),
    .wb_rm       (wb_rm),
    .wb_fflags   (wb_fflags),
    .wb_ack      (wb_ack)
  );

  fp_wb_round i_fp_wb_round (
    .clk           (clk),
    .arst_n        (arst_n),
    .wb_done       (wb_done),
    .wb_id         (wb_id),
    .wb_rd         (wb_rd),
    .wb_grs        (wb_grs),
    .wb_rm         (wb_rm),
    .wb_fflags     (wb_fflags),
    .wb_ack        (wb_ack),
    .result_valid  (result_valid),
    .result        (result),
    .result_id     (result_id),
    .result_fflags (result_fflags),
    .result_ack    (result_ack)
  );

endmodule

//--- rtl/fp_wb_round.sv
`timescale 1ns/1ps
`include "fp_sqrt_config.svh"

module fp_wb_round (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        wb_done,
  input  logic [`FP_ID_WIDTH-1:0]     wb_id,
  input  logic [`FP_FLEN-1:0]         wb_rd,
  input  logic [2:0]                  wb_grs,
  input  fp_sqrt_pkg::rounding_mode_t wb_rm,
  input  logic [4:0]                  wb_fflags,
  output logic                        wb_ack,
  output logic                        result_valid,
  output logic [`FP_FLEN-1:0]         result,
  output logic [`FP_ID_WIDTH-1:0]     result_id,
  output logic [4:0]                  result_fflags,
  input  logic                        result_ack
);
  import fp_sqrt_pkg::*;

  localparam int FLEN = `FP_FLEN;

  logic            sign;
  logic            lsb;
  logic            guard;
  logic            rnd;
  logic            sticky;
  logic            roundup;
  logic [FLEN-2:0] magnitude;

  assign sign = wb_rd[FLEN-1];
  assign lsb  = wb_rd[0];
  assign {guard, rnd, sticky} = wb_grs;

  always_comb begin
    case (wb_rm)
      RNE:     roundup = guard & (rnd | sticky | lsb);
      RTZ:     roundup = 1'b0;
      RDN:     roundup = sign & (guard | rnd | sticky);
      RUP:     roundup = ~sign & (guard | rnd | sticky);
      RMM:     roundup = guard;
      default: roundup = 1'b0;
    endcase
  end

  // expo and frac as one field, carry walks into the exponent
  assign magnitude = wb_rd[FLEN-2:0] + {{(FLEN-2){1'b0}}, roundup};

  // take a new result when the output slot frees up
  assign wb_ack = wb_done & (~result_valid | result_ack);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result_valid <= 1'b0;
    end else if (wb_ack) begin
      result_valid <= 1'b1;
    end else if (result_ack) begin
      result_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_ack) begin
      result        <= {sign, magnitude};
      result_id     <= wb_id;
      result_fflags <= wb_fflags;
    end
  end

endmodule

//--- verif/fp_sqrt_assert.sv
`timescale 1ns/1ps
`include "fp_sqrt_config.svh"

module fp_sqrt_assert (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     new_request,
  input  logic                     ready,
  input  logic                     result_valid,
  input  logic                     result_ack,
  input  logic [`FP_FLEN-1:0]      result,
  input  logic [`FP_ID_WIDTH-1:0]  result_id,
  input  logic [4:0]               result_fflags,
  input  logic                     mant_start,
  input  logic                     mant_early,
  input  logic                     mant_done,
  input  fp_sqrt_pkg::sqrt_state_t mant_state
);
  import fp_sqrt_pkg::*;

  localparam int ITER = `FP_SQRT_ITER;

  //////////////////////////////////////////////////
  // issue and result handshakes
  request_needs_ready: assert property (
    @(posedge clk) disable iff (!arst_n) new_request |-> ready
  ) else $error("new_request seen while ready is low");

  result_holds: assert property (
    @(posedge clk) disable iff (!arst_n)
    (result_valid && !result_ack) |=> (result_valid && $stable(result) &&
                                       $stable(result_id) && $stable(result_fflags))
  ) else $error("result dropped or changed before result_ack");

  //////////////////////////////////////////////////
  // mantissa core timing
  // core stays busy without done until the last root bit
  mant_full_latency: assert property (
    @(posedge clk) disable iff (!arst_n)
    (mant_start && !mant_early) |=>
      (!mant_done && (mant_state == SQ_BUSY)) [*(ITER-1)] ##1 mant_done
  ) else $error("mantissa done not ITER cycles after start");

  mant_early_latency: assert property (
    @(posedge clk) disable iff (!arst_n)
    (mant_start && mant_early) |=> mant_done
  ) else $error("early terminated op did not finish next cycle");

endmodule

bind fp_sqrt_top fp_sqrt_assert i_fp_sqrt_assert (
  .clk           (clk),
  .arst_n        (arst_n),
  .new_request   (new_request),
  .ready         (ready),
  .result_valid  (result_valid),
  .result_ack    (result_ack),
  .result        (result),
  .result_id     (result_id),
  .result_fflags (result_fflags),
  .mant_start    (i_fp_sqrt.i_sqrt_mantissa.start),
  .mant_early    (i_fp_sqrt.i_sqrt_mantissa.early_terminate),
  .mant_done     (i_fp_sqrt.i_sqrt_mantissa.done),
  .mant_state    (i_fp_sqrt.i_sqrt_mantissa.state)
);

//--- verif/fp_sqrt_patterns.txt
// operand  rm  expected  fflags(nv dz of uf nx)
// rm: 0 rne, 1 rtz, 2 rdn, 3 rup, 4 rmm
40800000 0 40000000 00
40000000 0 3fb504f3 01
41100000 0 40400000 00
3f000000 0 3f3504f3 01
40400000 0 3fddb3d7 01
41800000 0 40800000 00
3e800000 0 3f000000 00
40a00000 0 400f1bbd 01
40000000 1 3fb504f3 01
40000000 2 3fb504f3 01
40000000 3 3fb504f4 01
40000000 4 3fb504f3 01
40400000 1 3fddb3d7 01
40400000 2 3fddb3d7 01
40400000 3 3fddb3d8 01
40400000 4 3fddb3d7 01
40a00000 1 400f1bbc 01
40a00000 4 400f1bbd 01
3f000000 3 3f3504f4 01
407fffff 0 3fffffff 01
407fffff 1 3fffffff 01
407fffff 3 40000000 01
7fc00000 0 7fc00000 00
ffc12345 0 7fc00000 00
7f800001 0 7fc00000 10
c0800000 0 7fc00000 10
ff800000 0 7fc00000 10
7f800000 0 7f800000 00
00000000 0 00000000 00
80000000 0 80000000 00
00000001 0 00000000 00
80400000 0 80000000 00
3f800000 0 3f800000 00
3f800000 3 3f800000 00

//--- verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic arst_n
);

  localparam int HALF_PERIOD  = 2;   // 4 ns clock
  localparam int RESET_CYCLES = 10;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;  // release away from the rising edge
  end

endmodule

//--- verif/tb_fp_sqrt.sv
`timescale 1ns/1ps
`include "fp_sqrt_config.svh"

module tb_fp_sqrt;
  import fp_sqrt_pkg::*;

  localparam int MAX_CASES = 64;
  localparam int TIMEOUT   = 200;

  logic                    clk;
  logic                    arst_n;
  logic                    new_request;
  logic [`FP_ID_WIDTH-1:0] id;
  logic [`FP_FLEN-1:0]     rs1;
  rounding_mode_t          rm;
  logic                    ready;
  logic                    result_valid;
  logic [`FP_FLEN-1:0]     result;
  logic [`FP_ID_WIDTH-1:0] result_id;
  logic [4:0]              result_fflags;
  logic                    result_ack;

  // four words per case: operand, rm, expected result, expected fflags
  logic [31:0]             pat_mem [0:4*MAX_CASES-1];
  int                      num_cases;
  int                      outstanding;  // accepted but not yet acked
  logic [`FP_ID_WIDTH-1:0] next_tag;

  logic [`FP_FLEN-1:0]     exp_result_q [$];
  logic [`FP_ID_WIDTH-1:0] exp_id_q [$];
  logic [4:0]              exp_fflags_q [$];
  int                      exp_case_q [$];

  tb_clk_gen i_clk_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  fp_sqrt_top i_dut (
    .clk           (clk),
    .arst_n        (arst_n),
    .new_request   (new_request),
    .id            (id),
    .rs1           (rs1),
    .rm            (rm),
    .ready         (ready),
    .result_valid  (result_valid),
    .result        (result),
    .result_id     (result_id),
    .result_fflags (result_fflags),
    .result_ack    (result_ack)
  );

  //////////////////////////////////////////////////
  // helpers
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_result(input logic [`FP_FLEN-1:0] got,
                              input logic [`FP_FLEN-1:0] exp, input int idx);
    if (got !== exp) begin
      $display("Error at time %0t: case %0d result %08h, expected %08h", $time, idx, got, exp);
      abort_run();
    end
  endtask

  task automatic check_id(input logic [`FP_ID_WIDTH-1:0] got,
                          input logic [`FP_ID_WIDTH-1:0] exp, input int idx);
    if (got !== exp) begin
      $display("Error at time %0t: case %0d tag %0h, expected %0h", $time, idx, got, exp);
      abort_run();
    end
  endtask

  task automatic check_fflags(input logic [4:0] got, input logic [4:0] exp, input int idx);
    if (got !== exp) begin
      $display("Error at time %0t: case %0d fflags %05b, expected %05b", $time, idx, got, exp);
      abort_run();
    end
  endtask

  // specials finish in the issue side, normals run the full core
  function automatic int expected_latency(input logic [`FP_FLEN-1:0] op);
    logic [`FP_EXPO_WIDTH-1:0] e;
    logic [`FP_FLEN-1:0]       one;
    e   = op[`FP_FLEN-2 -: `FP_EXPO_WIDTH];
    one = {1'b0, `FP_EXPO_WIDTH'(`FP_BIAS), {`FP_FRAC_WIDTH{1'b0}}};
    if (op[`FP_FLEN-1] || (e == '0) || (&e) || (op == one)) begin
      return 4;
    end
    return 30;
  endfunction

  task automatic wait_ready();
    int n;
    n = 0;
    while (ready !== 1'b1) begin
      step();
      n++;
      if (n >= TIMEOUT) begin
        $display("Timeout: ready stayed low for %0d cycles", TIMEOUT);
        abort_run();
      end
    end
  endtask

  task automatic issue_case(input int idx);
    wait_ready();
    new_request = 1'b1;
    id          = next_tag;
    rs1         = pat_mem[4*idx];
    rm          = rounding_mode_t'(pat_mem[4*idx+1][2:0]);
    exp_result_q.push_back(pat_mem[4*idx+2]);
    exp_id_q.push_back(next_tag);
    exp_fflags_q.push_back(pat_mem[4*idx+3][4:0]);
    exp_case_q.push_back(idx);
    next_tag = next_tag + 1'b1;  // round robin tags
    step();
    new_request = 1'b0;
    outstanding++;
  endtask

  task automatic receive_one(input int hold, output int waited);
    int n;
    int idx;
    n = 0;
    while (result_valid !== 1'b1) begin
      step();
      n++;
      if (n >= TIMEOUT) begin
        $display("Timeout: no result within %0d cycles", TIMEOUT);
        abort_run();
      end
    end
    waited = n;
    if (exp_result_q.size() == 0) begin
      $display("A result came back with no request outstanding");
      abort_run();
    end
    repeat (hold) step();  // back-pressure
    idx = exp_case_q.pop_front();
    check_result(result, exp_result_q.pop_front(), idx);
    check_id(result_id, exp_id_q.pop_front(), idx);
    check_fflags(result_fflags, exp_fflags_q.pop_front(), idx);
    result_ack = 1'b1;
    step();
    result_ack = 1'b0;
    outstanding--;
  endtask

  // queue, core and result register hold three ops at most
  always @(negedge clk) begin
    if ((arst_n === 1'b1) && (outstanding >= 3) && (ready === 1'b1)) begin
      $display("ready was high while the input queue was full");
      abort_run();
    end
  end

  //////////////////////////////////////////////////
  // main sequence
  initial begin
    int seed;
    int n;
    int waited;
    int dummy;
    new_request = 1'b0;
    id          = '0;
    rs1         = '0;
    rm          = RNE;
    result_ack  = 1'b0;
    outstanding = 0;
    next_tag    = '0;
    seed        = $urandom(32'h7d06);

    for (int i = 0; i < 4*MAX_CASES; i++) begin
      pat_mem[i] = 'x;
    end
    $readmemh("verif/fp_sqrt_patterns.txt", pat_mem);
    num_cases = 0;
    while ((num_cases < MAX_CASES) && !$isunknown(pat_mem[4*num_cases])) begin
      num_cases++;
    end
    if (num_cases == 0) begin
      $display("No test cases were read from the pattern file");
      abort_run();
    end

    n = 0;
    while (arst_n !== 1'b1) begin
      step();
      n++;
      if (n >= TIMEOUT) begin
        $display("Timeout: reset never released");
        abort_run();
      end
    end
    step();
    if ((result_valid !== 1'b0) || (ready !== 1'b1)) begin
      $display("After reset result_valid is not low or ready is not high");
      abort_run();
    end

    // one op at a time, exact latency
    for (int i = 0; i < num_cases; i++) begin
      issue_case(i);
      receive_one(0, waited);
      if (waited + 1 != expected_latency(pat_mem[4*i])) begin
        $display("Error at time %0t: case %0d latency %0d cycles, expected %0d",
                 $time, i, waited + 1, expected_latency(pat_mem[4*i]));
        abort_run();
      end
    end

    // back to back with random back-pressure
    fork
      begin
        for (int i = 0; i < num_cases; i++) begin
          issue_case(i);
        end
      end
      begin
        for (int k = 0; k < num_cases; k++) begin
          receive_one($urandom % 6, dummy);
        end
      end
    join

    if ((outstanding == 0) && (exp_result_q.size() == 0)) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("%0d results were never returned", exp_result_q.size());
      abort_run();
    end
  end

endmodule
